// ==== Bender.yml ====
package:
  name: backend

sources:
  - include_dirs:
      - src
    files:
      - src/backend_pkg.sv
      - src/dispatch.sv
      - src/int_block.sv
      - src/mem_block.sv
      - src/reorder_buffer.sv
      - src/backend.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/backend_props.sv
      - bench/backend_tb.sv

// ==== backend.f ====
+incdir+src
src/backend_pkg.sv
src/dispatch.sv
src/int_block.sv
src/mem_block.sv
src/reorder_buffer.sv
src/backend.sv
bench/backend_props.sv
bench/backend_tb.sv

// ==== bench/backend_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "backend_params.svh"

module backend_props (
    input wire logic                    clock,
    input wire logic                    arst_n,
    input wire logic                    mem_valid,
    input wire logic                    mem_ready,
    input wire logic                    commit_valid,
    input wire logic [`BE_ROB_ID_W-1:0] commit_id
);
    logic                    seen;
    logic [`BE_ROB_ID_W-1:0] last_id;
    logic [`BE_ROB_ID_W-1:0] next_id;
    int                      fail_count = 0;

    assign next_id = last_id + 1'b1; // wraps mod 8

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            seen    <= 1'b0;
            last_id <= '0;
        end else if (commit_valid) begin
            seen    <= 1'b1;
            last_id <= commit_id;
        end
    end

    assert property (@(posedge clock) !arst_n |-> !commit_valid)
        else begin
            fail_count++;
            $error("commit_valid high during reset");
        end

    assert property (@(posedge clock) disable iff (!arst_n)
        mem_valid && mem_ready |=> !mem_ready [*`BE_MEM_LAT])
        else begin
            fail_count++;
            $error("memory block ready before its latency elapsed");
        end

    assert property (@(posedge clock) disable iff (!arst_n)
        commit_valid && seen |-> commit_id == next_id)
        else begin
            fail_count++;
            $error("commit id does not follow the previous one");
        end

endmodule

bind backend backend_props props_inst (
    .clock       (clock),
    .arst_n      (arst_n),
    .mem_valid   (mem_valid),
    .mem_ready   (mem_ready),
    .commit_valid(commit_valid),
    .commit_id   (commit.rob_id)
);

`default_nettype wire

// ==== bench/backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "backend_params.svh"

module backend_tb;
    import backend_pkg::*;

    localparam int TOTAL_OPS = 40 + 16 + 30 + 60 + 40;

    logic                clock = 1'b0;
    logic                arst_n;
    logic                instr_valid;
    logic                instr_ready;
    op_e                 instr_op;
    logic [`BE_XLEN-1:0] instr_src1;
    logic [`BE_XLEN-1:0] instr_src2;
    logic                commit_valid;
    commit_t             commit;

    uop_t                    stim_q[$];
    commit_t                 exp_q[$];
    commit_t                 want;
    logic [`BE_XLEN-1:0]     model_mem [`BE_MEM_WORDS];
    logic [`BE_ROB_ID_W-1:0] next_id;
    int accepted = 0;
    int commits  = 0;
    int checks   = 0;
    int errors   = 0;
    int tests    = 0;

    backend backend_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_op    (instr_op),
        .instr_src1  (instr_src1),
        .instr_src2  (instr_src2),
        .commit_valid(commit_valid),
        .commit      (commit)
    );

    always #4 clock = ~clock;

    // expected commits in accept order and memory in program order
    task automatic model_accept(input uop_t u);
        commit_t e;
        e.rob_id = next_id;
        e.op     = u.op;
        case (u.op)
            op_add:   e.result = u.src1 + u.src2;
            op_sub:   e.result = u.src1 - u.src2;
            op_and:   e.result = u.src1 & u.src2;
            op_xor:   e.result = u.src1 ^ u.src2;
            op_load:  e.result = model_mem[u.src1[3:0]];
            default: begin
                model_mem[u.src1[3:0]] = u.src2;
                e.result = u.src2;
            end
        endcase
        exp_q.push_back(e);
        next_id = next_id + 1'b1; // wraps mod 8
        accepted++;
    endtask

    // kind 0 int, 1 load each address, 2 store/load on few words, 3 mix, 4 mem only
    task automatic build_ops(input int n, input int kind);
        uop_t u;
        stim_q.delete();
        for (int i = 0; i < n; i++) begin
            u.src1   = $urandom;
            u.src2   = $urandom;
            u.rob_id = '0;
            case (kind)
                0: u.op = op_e'($urandom % 4);
                1: begin
                    u.op   = op_load;
                    u.src1 = (u.src1 & 32'hffff_fff0) | i;
                end
                2: begin
                    u.op   = ($urandom % 2) ? op_load : op_store;
                    u.src1 = u.src1 & 32'hffff_fff3; // addresses 0..3 to force hits
                end
                3: u.op = op_e'($urandom % 6);
                default: u.op = ($urandom % 2) ? op_load : op_store;
            endcase
            stim_q.push_back(u);
        end
    endtask

    task automatic run_ops(input string name, input bit hold_valid);
        int idx;
        int err0;
        int acc0;
        int com0;
        bit took;
        idx  = 0;
        took = 1'b0;
        err0 = errors;
        acc0 = accepted;
        com0 = commits;
        while (idx < stim_q.size()) begin
            @(negedge clock);
            if (took) instr_valid = 1'b0;
            took = 1'b0;
            if (!instr_valid && (hold_valid || ($urandom % 4 != 0))) begin
                instr_valid = 1'b1;
                instr_op    = stim_q[idx].op;
                instr_src1  = stim_q[idx].src1;
                instr_src2  = stim_q[idx].src2;
            end
            #2; // handshake state is settled mid low phase
            if (instr_valid && instr_ready) begin
                took = 1'b1;
                model_accept(stim_q[idx]);
                idx++;
            end
        end
        @(negedge clock);
        instr_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clock);
        checks++;
        assert (commits - com0 == accepted - acc0) else begin
            errors++;
            $display("mismatch commit count: got %h expected %h", commits - com0, accepted - acc0);
        end
        tests++;
        $display("test %-12s %0d ops, %0d errors", name, accepted - acc0, errors - err0);
    endtask

    always @(negedge clock) begin
        if (arst_n && commit_valid) begin
            commits++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("commit seen while no micro-op was outstanding");
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                checks++;
                assert (commit.rob_id == want.rob_id) else begin
                    errors++;
                    $display("mismatch commit.rob_id: got %h expected %h",
                             commit.rob_id, want.rob_id);
                end
                assert (commit.op == want.op) else begin
                    errors++;
                    $display("mismatch commit.op: got %h expected %h", commit.op, want.op);
                end
                assert (commit.result == want.result) else begin
                    errors++;
                    $display("mismatch commit.result: got %h expected %h",
                             commit.result, want.result);
                end
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * 20 + 20) @(posedge clock);
        $display("timeout: commits stopped before all micro-ops retired");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h1343_1aef));
        arst_n      = 1'b1;
        instr_valid = 1'b0;
        instr_op    = op_add;
        instr_src1  = '0;
        instr_src2  = '0;
        next_id     = '0;
        for (int i = 0; i < `BE_MEM_WORDS; i++) model_mem[i] = '0;
        #1;
        arst_n = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        build_ops(40, 0);
        run_ops("int_ops", 1'b0);
        build_ops(16, 1); // before any store
        run_ops("reset_mem", 1'b0);
        build_ops(30, 2);
        run_ops("store_load", 1'b0);
        build_ops(60, 3);
        run_ops("ordering", 1'b0);
        build_ops(40, 4);
        run_ops("backpressure", 1'b1);
        errors = errors + backend_inst.props_inst.fail_count;
        $display("tests %0d, checks %0d, commits %0d, errors %0d", tests, checks, commits, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/backend.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "backend_params.svh"

module backend (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  backend_pkg::op_e     instr_op,
    input  logic [`BE_XLEN-1:0]  instr_src1,
    input  logic [`BE_XLEN-1:0]  instr_src2,
    output logic                 commit_valid,
    output backend_pkg::commit_t commit
);
    import backend_pkg::*;

    logic                    alloc_ok;
    logic [`BE_ROB_ID_W-1:0] alloc_id;
    logic                    alloc_req;
    logic                    int_valid;
    uop_t                    int_uop;
    logic                    mem_valid;
    logic                    mem_ready; // low while a load or store is in flight
    uop_t                    mem_uop;
    wb_t                     int_wb;
    wb_t                     mem_wb;

    dispatch dispatch_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .instr_valid(instr_valid),
        .instr_ready(instr_ready),
        .instr_op   (instr_op),
        .instr_src1 (instr_src1),
        .instr_src2 (instr_src2),
        .alloc_ok   (alloc_ok),
        .alloc_id   (alloc_id),
        .alloc_req  (alloc_req),
        .int_valid  (int_valid),
        .int_uop    (int_uop),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_uop    (mem_uop)
    );

    int_block int_block_inst (
        .clock (clock),
        .arst_n(arst_n),
        .valid (int_valid),
        .uop   (int_uop),
        .wb    (int_wb)
    );

    mem_block mem_block_inst (
        .clock (clock),
        .arst_n(arst_n),
        .valid (mem_valid),
        .ready (mem_ready),
        .uop   (mem_uop),
        .wb    (mem_wb)
    );

    reorder_buffer reorder_buffer_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .alloc_req   (alloc_req),
        .alloc_ok    (alloc_ok),
        .alloc_id    (alloc_id),
        .alloc_op    (instr_op), // op travels with the accepted transfer
        .int_wb      (int_wb),
        .mem_wb      (mem_wb),
        .commit_valid(commit_valid),
        .commit      (commit)
    );

endmodule

`default_nettype wire

// ==== src/backend_params.svh ====
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

// datapath width
`define BE_XLEN 32

// reorder buffer
`define BE_ROB_DEPTH 8
`define BE_ROB_ID_W 3 // log2 of depth

// scratch memory on the mem side
`define BE_MEM_WORDS 16
`define BE_MEM_LAT 2 // cycles from issue to writeback

`endif

// ==== src/backend_pkg.sv ====
`default_nettype none
`include "backend_params.svh"

package backend_pkg;

    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_and   = 3'd2,
        op_xor   = 3'd3,
        op_load  = 3'd4,
        op_store = 3'd5
    } op_e;

    typedef struct packed {
        op_e                     op;
        logic [`BE_XLEN-1:0]     src1;
        logic [`BE_XLEN-1:0]     src2;
        logic [`BE_ROB_ID_W-1:0] rob_id;
    } uop_t;

    typedef struct packed {
        logic                    valid;
        logic [`BE_ROB_ID_W-1:0] rob_id;
        logic [`BE_XLEN-1:0]     result;
    } wb_t;

    typedef struct packed {
        logic [`BE_ROB_ID_W-1:0] rob_id;
        op_e                     op;
        logic [`BE_XLEN-1:0]     result;
    } commit_t;

endpackage

`default_nettype wire

// ==== src/dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "backend_params.svh"

module dispatch (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  backend_pkg::op_e        instr_op,
    input  logic [`BE_XLEN-1:0]     instr_src1,
    input  logic [`BE_XLEN-1:0]     instr_src2,
    input  logic                    alloc_ok,
    input  logic [`BE_ROB_ID_W-1:0] alloc_id,
    output logic                    alloc_req,
    output logic                    int_valid,
    output backend_pkg::uop_t       int_uop,
    output logic                    mem_valid,
    input  logic                    mem_ready,
    output backend_pkg::uop_t       mem_uop
);
    import backend_pkg::*;

    logic held_valid;
    uop_t held_uop;
    logic goto_mem;
    logic drain;

    assign goto_mem = (held_uop.op == op_load) || (held_uop.op == op_store);
    assign drain    = held_valid && (goto_mem ? mem_ready : 1'b1); // int side never stalls

    // refill in the same cycle the old entry leaves
    assign instr_ready = alloc_ok && (!held_valid || drain);
    assign alloc_req   = instr_valid && instr_ready;

    assign int_valid = held_valid && !goto_mem;
    assign mem_valid = held_valid && goto_mem;
    assign int_uop   = held_uop;
    assign mem_uop   = held_uop;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            held_valid <= 1'b0;
        end else if (alloc_req) begin
            held_valid <= 1'b1;
        end else if (drain) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_req) begin
            held_uop <= '{op: instr_op, src1: instr_src1, src2: instr_src2, rob_id: alloc_id};
        end
    end

endmodule

`default_nettype wire

// ==== src/int_block.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "backend_params.svh"

module int_block (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              valid,
    input  backend_pkg::uop_t uop,
    output backend_pkg::wb_t  wb
);
    import backend_pkg::*;

    logic [`BE_XLEN-1:0]     alu_out;
    logic                    wb_valid;
    logic [`BE_ROB_ID_W-1:0] wb_id;
    logic [`BE_XLEN-1:0]     wb_result;

    always_comb begin
        case (uop.op)
            op_add:  alu_out = uop.src1 + uop.src2; // wraps mod 2^32
            op_sub:  alu_out = uop.src1 - uop.src2;
            op_and:  alu_out = uop.src1 & uop.src2;
            op_xor:  alu_out = uop.src1 ^ uop.src2;
            default: alu_out = '0; // mem ops never routed here
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= valid;
        end
    end

    always_ff @(posedge clock) begin
        if (valid) begin
            wb_id     <= uop.rob_id;
            wb_result <= alu_out;
        end
    end

    assign wb = '{valid: wb_valid, rob_id: wb_id, result: wb_result};

endmodule

`default_nettype wire

// ==== src/mem_block.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "backend_params.svh"

module mem_block (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              valid,
    output logic              ready,
    input  backend_pkg::uop_t uop,
    output backend_pkg::wb_t  wb
);
    import backend_pkg::*;

    localparam int CNT_W  = $clog2(`BE_MEM_LAT + 1);
    localparam int ADDR_W = $clog2(`BE_MEM_WORDS);

    logic [CNT_W-1:0]        busy_cnt;
    logic                    issue;
    op_e                     op_q;
    logic [ADDR_W-1:0]       addr_q;
    logic [`BE_XLEN-1:0]     data_q;
    logic [`BE_ROB_ID_W-1:0] id_q;
    logic [`BE_XLEN-1:0]     mem [`BE_MEM_WORDS];
    logic                    wb_valid;
    logic [`BE_ROB_ID_W-1:0] wb_id;
    logic [`BE_XLEN-1:0]     wb_result;

    assign ready = (busy_cnt == '0);
    assign issue = valid && ready;

    // counter, memory array and writeback flag
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt <= '0;
            wb_valid <= 1'b0;
            for (int i = 0; i < `BE_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            wb_valid <= (busy_cnt == CNT_W'(1)); // last busy cycle
            if (issue) begin
                busy_cnt <= CNT_W'(`BE_MEM_LAT);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            if (busy_cnt == CNT_W'(1) && op_q == op_store) begin
                mem[addr_q] <= data_q;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            op_q   <= uop.op;
            addr_q <= uop.src1[ADDR_W-1:0];
            data_q <= uop.src2;
            id_q   <= uop.rob_id;
        end
        if (busy_cnt == CNT_W'(1)) begin
            wb_id     <= id_q;
            wb_result <= (op_q == op_store) ? data_q : mem[addr_q]; // store echoes src2
        end
    end

    assign wb = '{valid: wb_valid, rob_id: wb_id, result: wb_result};

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "backend_params.svh"

module reorder_buffer (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    alloc_req,
    output logic                    alloc_ok,
    output logic [`BE_ROB_ID_W-1:0] alloc_id,
    input  backend_pkg::op_e        alloc_op,
    input  backend_pkg::wb_t        int_wb,
    input  backend_pkg::wb_t        mem_wb,
    output logic                    commit_valid,
    output backend_pkg::commit_t    commit
);
    import backend_pkg::*;

    logic [`BE_ROB_ID_W-1:0]  head;
    logic [`BE_ROB_ID_W-1:0]  tail;
    logic [`BE_ROB_ID_W:0]    count;
    logic [`BE_ROB_ID_W:0]    count_next;
    logic                     retire;
    logic [`BE_ROB_DEPTH-1:0] done_q;
    op_e                      op_q [`BE_ROB_DEPTH];
    logic [`BE_XLEN-1:0]      result_q [`BE_ROB_DEPTH];

    assign alloc_id = tail;
    assign retire   = (count != '0) && done_q[head]; // oldest entry only

    always_comb begin
        count_next = count;
        if (alloc_req && !retire) begin
            count_next = count + 1'b1;
        end else if (!alloc_req && retire) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done_q       <= '0;
            alloc_ok     <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            count        <= count_next;
            alloc_ok     <= (count_next != `BE_ROB_DEPTH); // registered, low in reset
            commit_valid <= retire;
            if (retire) begin
                done_q[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            if (alloc_req) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            // both units may finish in the same cycle
            if (int_wb.valid) begin
                done_q[int_wb.rob_id] <= 1'b1;
            end
            if (mem_wb.valid) begin
                done_q[mem_wb.rob_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_req) begin
            op_q[tail] <= alloc_op;
        end
        if (int_wb.valid) begin
            result_q[int_wb.rob_id] <= int_wb.result;
        end
        if (mem_wb.valid) begin
            result_q[mem_wb.rob_id] <= mem_wb.result;
        end
        if (retire) begin
            commit <= '{rob_id: head, op: op_q[head], result: result_q[head]};
        end
    end

endmodule

`default_nettype wire
